// ==== src/tile_params.svh ====
// Sizing macros for the tile engine, shared by the packages and RTL.
// Include wherever lane, beat or width constants are needed.
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// elements per operand beat
`define LANES 4

// beats per inner tile, also results per tile
`define BEATS 4

`define FIFO_DEPTH 4

// tile count field width
`define TILE_W 4

// accumulator and result width
`define ACC_W 24

`endif

// ==== src/apb_pkg.sv ====
// APB bus structs and the register map of the configuration block.
`default_nettype none

package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  localparam logic [7:0] REG_CTRL   = 8'h00; // bit 0 starts a run
  localparam logic [7:0] REG_TILES  = 8'h04; // tile_e, tile_p, tile_s nibbles
  localparam logic [7:0] REG_BIAS   = 8'h08; // signed 16 bit
  localparam logic [7:0] REG_STATUS = 8'h0C; // read only, bit 0 busy

endpackage

`default_nettype wire

// ==== src/tile_pkg.sv ====
// Datapath types of the tile engine: config, operands, tokens, results.
// Modules import this package for everything that crosses a port.
`default_nettype none

`include "tile_params.svh"

package tile_pkg;

  localparam int unsigned BEAT_W = $clog2(`BEATS);

  typedef logic signed [7:0] elem_t;

  typedef struct packed {
    logic                     start;   // one cycle pulse
    logic [`TILE_W-1:0]       tile_s;
    logic [`TILE_W-1:0]       tile_p;
    logic [`TILE_W-1:0]       tile_e;
    logic signed [15:0]       bias;
  } cfg_t;

  typedef struct packed {
    elem_t [`LANES-1:0] inp;
    elem_t [`LANES-1:0] wgt;
  } operand_t;

  typedef struct packed {
    operand_t           opd;
    logic [BEAT_W-1:0]  beat;
    logic [`TILE_W-1:0] tile_x;
    logic [`TILE_W-1:0] tile_y;
    logic               first_inner;
    logic               last_inner;
  } token_t;

  typedef struct packed {
    logic [`TILE_W-1:0]       tile_x;
    logic [`TILE_W-1:0]       tile_y;
    logic [BEAT_W-1:0]        beat;
    logic signed [`ACC_W-1:0] value;
  } result_t;

  typedef enum logic {
    Idle,
    MatMul
  } step_e;

endpackage

`default_nettype wire

// ==== src/tile_cfg_regs.sv ====
// APB slave for the engine configuration: tile counts, bias, start.
// Zero wait states; writes land at the end of the access phase.
`timescale 1ns/10ps
`default_nettype none

module tile_cfg_regs
  import apb_pkg::*;
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     busy_i,
  output cfg_t     cfg_o
);

  logic        access, wr_en;
  logic        start_q;
  logic [11:0] tiles_q;
  logic [15:0] bias_q;
  logic        addr_ok;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  always_comb begin
    addr_ok          = 1'b1;
    apb_rsp_o.prdata = '0;
    case (apb_req_i.paddr)
      REG_CTRL:   apb_rsp_o.prdata = '0; // start bit self clears
      REG_TILES:  apb_rsp_o.prdata = {20'h0, tiles_q};
      REG_BIAS:   apb_rsp_o.prdata = {16'h0, bias_q};
      REG_STATUS: apb_rsp_o.prdata = {31'h0, busy_i};
      default:    addr_ok = 1'b0;
    endcase
    apb_rsp_o.pready  = 1'b1;
    // status is read only
    apb_rsp_o.pslverr = access & (~addr_ok | (apb_req_i.pwrite & (apb_req_i.paddr == REG_STATUS)));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      tiles_q <= 12'h111; // one tile of each
      bias_q  <= '0;
    end else begin
      start_q <= wr_en & (apb_req_i.paddr == REG_CTRL) & apb_req_i.pwdata[0];
      if (wr_en && apb_req_i.paddr == REG_TILES) tiles_q <= apb_req_i.pwdata[11:0];
      if (wr_en && apb_req_i.paddr == REG_BIAS) bias_q <= apb_req_i.pwdata[15:0];
    end
  end

  assign cfg_o.start  = start_q;
  assign cfg_o.tile_s = tiles_q[3:0];
  assign cfg_o.tile_p = tiles_q[7:4];
  assign cfg_o.tile_e = tiles_q[11:8];
  assign cfg_o.bias   = bias_q;

endmodule

`default_nettype wire

// ==== src/tile_controller.sv ====
// Tile sequencer for the MatMul layer. Walks tiles, inner tiles and beats,
// tags each accepted operand beat and pushes it as a token.
`timescale 1ns/10ps
`default_nettype none

`include "tile_params.svh"

module tile_controller
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cfg_t     cfg_i,
  input  logic     opd_valid_i,
  input  operand_t opd_i,
  output logic     opd_ready_o,
  output logic     push_valid_o,
  output token_t   push_token_o,
  input  logic     push_ready_i,
  output logic     busy_o
);

  step_e                step_d, step_q;
  logic [BEAT_W-1:0]    beat_d, beat_q;
  logic [`TILE_W-1:0]   inner_d, inner_q;
  logic [`TILE_W-1:0]   tile_x_d, tile_x_q;
  logic [`TILE_W-1:0]   tile_y_d, tile_y_q;
  logic [2*`TILE_W-1:0] tile_d, tile_q;
  logic [2*`TILE_W-1:0] tile_total;
  logic                 last_inner, accept;

  assign tile_total = cfg_i.tile_s * cfg_i.tile_p;
  assign last_inner = (inner_q == cfg_i.tile_e - 1'b1);

  // FIFO full is the only back-pressure
  assign opd_ready_o  = (step_q == MatMul) & push_ready_i;
  assign push_valid_o = (step_q == MatMul) & opd_valid_i;
  assign accept       = opd_valid_i & opd_ready_o;
  assign busy_o       = (step_q == MatMul);

  assign push_token_o.opd         = opd_i;
  assign push_token_o.beat        = beat_q;
  assign push_token_o.tile_x      = tile_x_q;
  assign push_token_o.tile_y      = tile_y_q;
  assign push_token_o.first_inner = (inner_q == '0);
  assign push_token_o.last_inner  = last_inner;

  always_comb begin
    step_d   = step_q;
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    tile_d   = tile_q;

    if (step_q == Idle) begin
      if (cfg_i.start) begin
        step_d   = MatMul;
        beat_d   = '0;
        inner_d  = '0;
        tile_x_d = '0;
        tile_y_d = '0;
        tile_d   = '0;
      end
    end else if (accept) begin
      beat_d = beat_q + 1'b1;
      if (beat_q == BEAT_W'(`BEATS - 1)) begin // end of inner tile
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (last_inner) begin
          inner_d = '0;
          tile_d  = tile_q + 1'b1;
          if (tile_x_q == cfg_i.tile_p - 1'b1) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
          end else begin
            tile_x_d = tile_x_q + 1'b1;
          end
          if (tile_q == tile_total - 1'b1) step_d = Idle; // last tile done
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= Idle;
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      tile_q   <= '0;
    end else begin
      step_q   <= step_d;
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      tile_q   <= tile_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/token_fifo.sv ====
// Circular-buffer FIFO with a valid/ready port on each side.
// The payload is a type parameter; a push is accepted when full if a pop happens.
`timescale 1ns/10ps
`default_nettype none

`include "tile_params.svh"

module token_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned DEPTH = `FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t                   mem [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push, pop;

  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];
  assign push_ready_o = (count_q != DEPTH[$bits(count_q)-1:0]) | pop_ready_i;
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/dot_accumulator.sv ====
// Consumes tokens, forms the lane dot product and accumulates it per beat
// over the inner tiles. Last inner tile loads one biased result for output.
`timescale 1ns/10ps
`default_nettype none

`include "tile_params.svh"

module dot_accumulator
  import tile_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic signed [15:0] bias_i,
  input  logic               tok_valid_i,
  input  token_t             tok_i,
  output logic               tok_ready_o,
  output logic               res_valid_o,
  output result_t            res_o,
  input  logic               res_ready_i
);

  logic signed [`ACC_W-1:0] psum_q [`BEATS];
  logic signed [`ACC_W-1:0] dot, base, sum;
  logic                     res_valid_q;
  result_t                  res_q;
  logic                     pop;

  always_comb begin
    dot = '0;
    for (int i = 0; i < `LANES; i++) begin
      dot = dot + $signed(tok_i.opd.inp[i]) * $signed(tok_i.opd.wgt[i]);
    end
    base = tok_i.first_inner ? '0 : psum_q[tok_i.beat]; // restart on first inner
    sum  = base + dot;
  end

  // last_inner tokens wait for a free result slot
  assign tok_ready_o = ~tok_i.last_inner | ~res_valid_q | res_ready_i;
  assign pop         = tok_valid_i & tok_ready_o;

  always_ff @(posedge clk_i) begin
    if (pop && !tok_i.last_inner) psum_q[tok_i.beat] <= sum;
    if (pop && tok_i.last_inner) begin
      res_q.tile_x <= tok_i.tile_x;
      res_q.tile_y <= tok_i.tile_y;
      res_q.beat   <= tok_i.beat;
      res_q.value  <= sum + bias_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (pop && tok_i.last_inner) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0; // drained
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

`default_nettype wire

// ==== src/tile_engine_top.sv ====
// Top level of the tile engine: APB registers, tile controller,
// token FIFO and dot-product accumulator.
`timescale 1ns/10ps
`default_nettype none

module tile_engine_top
  import apb_pkg::*;
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     opd_valid_i,
  input  operand_t opd_i,
  output logic     opd_ready_o,
  output logic     res_valid_o,
  output result_t  res_o,
  input  logic     res_ready_i
);

  cfg_t   cfg;
  logic   busy;
  logic   push_valid, push_ready;
  token_t push_token;
  logic   pop_valid, pop_ready;
  token_t pop_token;

  tile_cfg_regs i_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .busy_i    (busy),
    .cfg_o     (cfg)
  );

  tile_controller i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg),
    .opd_valid_i  (opd_valid_i),
    .opd_i        (opd_i),
    .opd_ready_o  (opd_ready_o),
    .push_valid_o (push_valid),
    .push_token_o (push_token),
    .push_ready_i (push_ready),
    .busy_o       (busy)
  );

  token_fifo #(.payload_t(token_t)) i_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (push_valid),
    .push_data_i  (push_token),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_data_o   (pop_token),
    .pop_ready_i  (pop_ready)
  );

  dot_accumulator i_acc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bias_i      (cfg.bias),
    .tok_valid_i (pop_valid),
    .tok_i       (pop_token),
    .tok_ready_o (pop_ready),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Clock and reset source for the testbench.
// 8 ns clock, active-low reset held for the first 16 cycles.
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o); // release away from the rising edge
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/tile_engine_assertions.sv ====
// Handshake checks bound into the engine top level.
// Each property raises its own flag when it fails.
`timescale 1ns/10ps
`default_nettype none

module tile_engine_assertions
  import apb_pkg::*;
  import tile_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input apb_rsp_t apb_rsp_o,
  input logic     opd_valid_i,
  input operand_t opd_i,
  input logic     opd_ready_o,
  input logic     res_valid_o,
  input result_t  res_o,
  input logic     res_ready_i
);

  bit opd_stall_bad  = 1'b0;
  bit res_stall_bad  = 1'b0;
  bit reset_res_bad  = 1'b0;
  bit pready_bad     = 1'b0;

  // a stalled operand beat stays offered and unchanged
  opd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    opd_valid_i && !opd_ready_o |=> opd_valid_i && $stable(opd_i))
    else begin
      opd_stall_bad = 1'b1;
      $error("operand beat dropped or changed while stalled");
    end

  res_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else begin
      res_stall_bad = 1'b1;
      $error("result dropped or changed while stalled");
    end

  res_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !res_valid_o)
    else begin
      reset_res_bad = 1'b1;
      $error("result valid during reset");
    end

  // zero wait states
  pready_high: assert property (@(posedge clk_i) apb_rsp_o.pready)
    else begin
      pready_bad = 1'b1;
      $error("pready low");
    end

endmodule

bind tile_engine_top tile_engine_assertions i_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .apb_rsp_o   (apb_rsp_o),
  .opd_valid_i (opd_valid_i),
  .opd_i       (opd_i),
  .opd_ready_o (opd_ready_o),
  .res_valid_o (res_valid_o),
  .res_o       (res_o),
  .res_ready_i (res_ready_i)
);

`default_nettype wire

// ==== test/tile_engine_tb.sv ====
// Testbench for the tile engine. Checks the APB registers, then runs random
// MatMul tiles against a queue of expected results built from the sent operands.
`timescale 1ns/10ps
`default_nettype none

`include "tile_params.svh"

module tile_engine_tb
  import apb_pkg::*;
  import tile_pkg::*;
();

  localparam int SAMPLE_DLY = 3; // ns after the falling edge to sample outputs
  localparam int WAIT_LIMIT = 2000;

  logic        clk, rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        opd_valid, opd_ready;
  operand_t    opd;
  logic        res_valid, res_ready;
  result_t     res;
  logic [31:0] rng_q;
  int          checks, errors, got_cnt;
  operand_t    opd_q [$];
  result_t     exp_q [$];

  tb_clock i_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tile_engine_top DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .opd_valid_i (opd_valid),
    .opd_i       (opd),
    .opd_ready_o (opd_ready),
    .res_valid_o (res_valid),
    .res_o       (res),
    .res_ready_i (res_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1; // setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #SAMPLE_DLY;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    compare("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic apb_check_read(input logic [7:0] addr, input logic [31:0] exp_data,
                                input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    compare("pslverr", 32'(exp_err), 32'(err));
    if (!exp_err) compare("prdata", exp_data, rdata);
  endtask

  // expected results follow tile, inner, beat order
  task automatic build_run(input int ts, input int tp, input int te, input int bias);
    int       psum [`BEATS];
    int       dot, t, i, b, l;
    operand_t o;
    result_t  e;
    opd_q.delete();
    exp_q.delete();
    for (t = 0; t < ts * tp; t++) begin
      for (i = 0; i < te; i++) begin
        for (b = 0; b < `BEATS; b++) begin
          dot = 0;
          for (l = 0; l < `LANES; l++) begin
            rng_q    = xorshift(rng_q);
            o.inp[l] = rng_q[7:0];
            o.wgt[l] = rng_q[15:8];
            dot += int'($signed(o.inp[l])) * int'($signed(o.wgt[l]));
          end
          opd_q.push_back(o);
          psum[b] = (i == 0) ? dot : psum[b] + dot;
          if (i == te - 1) begin
            e.tile_x = `TILE_W'(t % tp);
            e.tile_y = `TILE_W'(t / tp);
            e.beat   = BEAT_W'(b);
            e.value  = `ACC_W'(psum[b] + bias);
            exp_q.push_back(e);
          end
        end
      end
    end
  endtask

  task automatic send_operands(input bit gaps);
    logic [31:0] s;
    int          idle;
    bit          taken;
    s     = ~rng_q;
    idle  = 0;
    taken = 1'b0;
    while (opd_q.size() > 0 && idle < WAIT_LIMIT) begin
      @(negedge clk);
      s = xorshift(s);
      if (taken) opd_valid = 1'b0;
      taken = 1'b0;
      if (!opd_valid) begin // an offered beat is held until taken
        opd_valid = !gaps || (s[1:0] != 2'b00);
        opd       = opd_q[0];
      end
      #SAMPLE_DLY;
      if (opd_valid && opd_ready) begin
        void'(opd_q.pop_front());
        taken = 1'b1;
        idle  = 0;
      end else begin
        idle++;
      end
    end
    if (opd_q.size() > 0) report_failure("operand stream never drained, opd_ready_o stuck low");
    @(negedge clk);
    opd_valid = 1'b0;
  endtask

  task automatic collect_results(input bit stalls);
    logic [31:0] s;
    int          idle, stall_left;
    result_t     e;
    s          = {rng_q[15:0], rng_q[31:16]};
    idle       = 0;
    stall_left = 0;
    got_cnt    = 0;
    while (exp_q.size() > 0 && idle < WAIT_LIMIT) begin
      @(negedge clk);
      s = xorshift(s);
      if (stall_left > 0) begin
        res_ready  = 1'b0;
        stall_left--;
      end else if (stalls && s[3:0] < 4'd3) begin
        res_ready  = 1'b0;
        stall_left = int'(s[7:4]); // low period up to 16 cycles
      end else begin
        res_ready = 1'b1;
      end
      #SAMPLE_DLY;
      if (res_valid && res_ready) begin
        e = exp_q.pop_front();
        got_cnt++;
        compare("res_o.tile_x", 32'(e.tile_x), 32'(res.tile_x));
        compare("res_o.tile_y", 32'(e.tile_y), 32'(res.tile_y));
        compare("res_o.beat", 32'(e.beat), 32'(res.beat));
        compare("res_o.value", 32'(e.value), 32'(res.value));
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (exp_q.size() > 0) report_failure("timed out waiting for results");
  endtask

  // late results count on top of the collected ones
  task automatic check_no_extra();
    int n;
    @(negedge clk);
    res_ready = 1'b1;
    for (n = 0; n < 16; n++) begin
      #SAMPLE_DLY;
      if (res_valid) got_cnt++;
      @(negedge clk);
    end
  endtask

  task automatic probe_busy();
    apb_check_read(REG_STATUS, 32'h1, 1'b0);
    apb_write(REG_CTRL, 32'h1, 1'b0); // start while busy
    apb_check_read(REG_STATUS, 32'h1, 1'b0);
  endtask

  task automatic run_matmul(input int ts, input int tp, input int te, input int bias,
                            input bit gaps, input bit stalls, input bit probe);
    int exp_cnt;
    build_run(ts, tp, te, bias);
    exp_cnt = ts * tp * `BEATS;
    apb_write(REG_TILES, {20'h0, te[3:0], tp[3:0], ts[3:0]}, 1'b0);
    apb_write(REG_BIAS, {16'h0, bias[15:0]}, 1'b0);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    fork
      send_operands(gaps);
      collect_results(stalls);
      begin
        if (probe) probe_busy();
      end
    join
    check_no_extra();
    compare("result count", 32'(exp_cnt), 32'(got_cnt));
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int errs0, k, n;
    int ts_a [4];
    int tp_a [4];
    int te_a [4];
    int bias_a [4];
    apb_req   = '0;
    opd_valid = 1'b0;
    opd       = '0;
    res_ready = 1'b0;
    rng_q     = 32'h561d;
    checks    = 0;
    errors    = 0;
    got_cnt   = 0;

    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) report_failure("reset was never released");

    errs0 = errors;
    #SAMPLE_DLY;
    compare("opd_ready_o", 32'h0, 32'(opd_ready));
    compare("res_valid_o", 32'h0, 32'(res_valid));
    compare("pslverr", 32'h0, 32'(apb_rsp.pslverr));
    apb_check_read(REG_STATUS, 32'h0, 1'b0);
    apb_write(REG_TILES, 32'h0000_0321, 1'b0);
    apb_check_read(REG_TILES, 32'h0000_0321, 1'b0);
    apb_write(REG_BIAS, 32'h0000_8a5c, 1'b0);
    apb_check_read(REG_BIAS, 32'h0000_8a5c, 1'b0);
    apb_check_read(8'h10, 32'h0, 1'b1); // unmapped
    apb_write(8'h14, 32'h0, 1'b1);
    apb_write(REG_STATUS, 32'h1, 1'b1);
    end_test(1, "registers after reset", errs0);

    errs0 = errors;
    rng_q = xorshift(rng_q);
    run_matmul(1, 1, 1, int'($signed(rng_q[15:0])), 1'b0, 1'b0, 1'b0);
    end_test(2, "single tile", errs0);

    errs0 = errors;
    for (k = 0; k < 4; k++) begin
      rng_q     = xorshift(rng_q);
      ts_a[k]   = 1 + int'(rng_q[7:0]) % 3;
      tp_a[k]   = 1 + int'(rng_q[15:8]) % 3;
      te_a[k]   = 1 + int'(rng_q[23:16]) % 3;
      rng_q     = xorshift(rng_q);
      bias_a[k] = int'($signed(rng_q[15:0]));
      run_matmul(ts_a[k], tp_a[k], te_a[k], bias_a[k], 1'b1, 1'b0, 1'b0);
    end
    end_test(3, "random multi-tile runs", errs0);

    errs0 = errors;
    for (k = 0; k < 4; k++) begin
      run_matmul(ts_a[k], tp_a[k], te_a[k], bias_a[k], 1'b1, 1'b1, 1'b0);
    end
    end_test(4, "runs with result back-pressure", errs0);

    errs0 = errors;
    rng_q = xorshift(rng_q);
    run_matmul(2, 2, 2, int'($signed(rng_q[15:0])), 1'b1, 1'b0, 1'b1);
    apb_check_read(REG_STATUS, 32'h0, 1'b0); // idle again
    end_test(5, "busy status and ignored start", errs0);

    if (DUT.i_assert.opd_stall_bad || DUT.i_assert.res_stall_bad ||
        DUT.i_assert.reset_res_bad || DUT.i_assert.pready_bad) begin
      report_failure("a bound handshake assertion failed");
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/apb_pkg.sv
src/tile_pkg.sv
src/tile_cfg_regs.sv
src/tile_controller.sv
src/token_fifo.sv
src/dot_accumulator.sv
src/tile_engine_top.sv
test/tb_clock.sv
test/tile_engine_assertions.sv
test/tile_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the tile engine testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tile_engine_tb -Mdir obj_dir -o tile_engine_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tile_engine_sim +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1
